// File: common/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

`define FN_SLL     6'h00
`define FN_JR      6'h08
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_SLT     6'h2a

`define ALU_ADD    4'd0
`define ALU_SUB    4'd1
`define ALU_AND    4'd2
`define ALU_OR     4'd3
`define ALU_SLT    4'd4
`define ALU_SLL    4'd5
`define ALU_LUI    4'd6

`define PC_RESET   32'h0000_3000
`define REG_RA     5'd31

`define WB_ALU     2'd0
`define WB_MEM     2'd1
`define WB_LINK    2'd2

// Operand sources for the forwarding muxes
`define FWD_RF     2'd0
`define FWD_MA     2'd1
`define FWD_WB     2'd2

`endif

// File: common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  wb_sel_t;
    typedef logic [1:0]  fwd_sel_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      alu_src_imm;   // B operand is the immediate
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        wb_sel_t   wb_sel;
        reg_addr_t dst;           // Resolved in decode
        logic      is_branch;
        logic      branch_ne;
        logic      is_jump;
        logic      is_jr;
        logic      uses_rs;
        logic      uses_rt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     rd1;
        word_t     rd2;
        word_t     imm;
        word_t     pc;
    } id_ex_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t alu_result;
        word_t store_data;
        word_t pc;
    } ex_ma_t;

    typedef struct packed {
        logic      reg_write;
        wb_sel_t   wb_sel;
        reg_addr_t dst;
        word_t     alu_result;
        word_t     load_data;
        word_t     pc;
    } ma_wb_t;

endpackage

`default_nettype wire

// File: hw/pc_unit.sv
`default_nettype none

`include "mips_consts.svh"

module pc_unit import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        branch_taken,
    input  logic        jump,
    input  logic        jump_reg,
    input  word_t       delay_pc,
    input  word_t       imm,
    input  logic [25:0] index,
    input  word_t       jr_target,
    output word_t       pc
);

    word_t pc_plus4;
    word_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (jump_reg) begin
            next_pc = jr_target;
        end else if (jump) begin
            next_pc = {delay_pc[31:28], index, 2'b00};   // Region of the delay slot
        end else if (branch_taken) begin
            next_pc = delay_pc + {imm[29:0], 2'b00};
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `PC_RESET;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/decoder.sv
`default_nettype none

`include "mips_consts.svh"

module decoder import mips_pkg::*; (
    input  word_t instr,
    output ctrl_t ctrl,
    output word_t imm
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = `ALU_ADD;
        ctrl.wb_sel = `WB_ALU;
        imm         = {{16{instr[15]}}, instr[15:0]};
        case (opcode)
            `OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.dst       = rd;
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
                case (funct)
                    `FN_ADDU: ctrl.alu_op = `ALU_ADD;
                    `FN_SUBU: ctrl.alu_op = `ALU_SUB;
                    `FN_AND:  ctrl.alu_op = `ALU_AND;
                    `FN_OR:   ctrl.alu_op = `ALU_OR;
                    `FN_SLT:  ctrl.alu_op = `ALU_SLT;
                    `FN_SLL: begin
                        ctrl.alu_op      = `ALU_SLL;
                        ctrl.alu_src_imm = 1'b1;
                        ctrl.uses_rs     = 1'b0;
                        imm              = {27'd0, instr[10:6]};   // Shift amount
                    end
                    `FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.is_jr     = 1'b1;
                        ctrl.uses_rt   = 1'b0;
                    end
                    default: ctrl = '0;   // Unsupported funct runs as a nop
                endcase
            end
            `OP_ADDIU, `OP_ORI, `OP_LUI, `OP_LW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.dst         = rt;
                ctrl.uses_rs     = (opcode != `OP_LUI);
                if (opcode == `OP_ORI) begin
                    ctrl.alu_op = `ALU_OR;
                    imm         = {16'd0, instr[15:0]};
                end else if (opcode == `OP_LUI) begin
                    ctrl.alu_op = `ALU_LUI;
                    imm         = {instr[15:0], 16'd0};
                end else if (opcode == `OP_LW) begin
                    ctrl.mem_read = 1'b1;
                    ctrl.wb_sel   = `WB_MEM;
                end
            end
            `OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                ctrl.uses_rs     = 1'b1;
                ctrl.uses_rt     = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = (opcode == `OP_BNE);
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
            end
            `OP_J, `OP_JAL: begin
                ctrl.is_jump = 1'b1;
                if (opcode == `OP_JAL) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = `WB_LINK;
                    ctrl.dst       = `REG_RA;
                end
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];
    logic  wr_live;

    assign wr_live = we && (waddr != 5'd0);   // $0 is never written

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write shows up on the read ports
    assign rdata1 = (wr_live && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wr_live && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/alu.sv
`default_nettype none

`include "mips_consts.svh"

module alu import mips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    logic slt_bit;

    assign slt_bit = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            `ALU_ADD: result = a + b;      // Also load/store address
            `ALU_SUB: result = a - b;
            `ALU_AND: result = a & b;
            `ALU_OR:  result = a | b;
            `ALU_SLT: result = {31'd0, slt_bit};
            `ALU_SLL: result = a << b[4:0];   // a carries rt here
            `ALU_LUI: result = b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`default_nettype none

`include "mips_consts.svh"

module hazard_unit import mips_pkg::*; (
    input  ctrl_t     id_ctrl,
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  id_ex_t    ex_stage,
    input  reg_addr_t ex_dst,
    input  ex_ma_t    ma_stage,
    input  ma_wb_t    wb_stage,
    output logic      stall,
    output fwd_sel_t  fwd_id_rs,
    output fwd_sel_t  fwd_id_rt,
    output fwd_sel_t  fwd_ex_rs,
    output fwd_sel_t  fwd_ex_rt
);

    logic reads_rs;
    logic reads_rt;
    logic ex_hit;
    logic ma_hit;
    logic id_compares;

    // Newest producer wins since MA loads have no data yet
    function automatic fwd_sel_t pick_src(input reg_addr_t r, input ex_ma_t ma,
                                          input ma_wb_t wb);
        fwd_sel_t sel;
        sel = `FWD_RF;
        if (r != 5'd0 && ma.ctrl.reg_write && !ma.ctrl.mem_read && ma.ctrl.dst == r) begin
            sel = `FWD_MA;
        end else if (r != 5'd0 && wb.reg_write && wb.dst == r) begin
            sel = `FWD_WB;
        end
        return sel;
    endfunction

    assign reads_rs    = id_ctrl.uses_rs && (id_rs != 5'd0);
    assign reads_rt    = id_ctrl.uses_rt && (id_rt != 5'd0);
    assign id_compares = id_ctrl.is_branch || id_ctrl.is_jr;   // Operands needed in ID

    // ex_dst is zero when EX writes nothing
    assign ex_hit = (reads_rs && id_rs == ex_dst) || (reads_rt && id_rt == ex_dst);
    assign ma_hit = (reads_rs && id_rs == ma_stage.ctrl.dst)
                 || (reads_rt && id_rt == ma_stage.ctrl.dst);

    assign stall = (ex_hit && ex_stage.ctrl.mem_read)
                || (ex_hit && id_compares)
                || (ma_hit && ma_stage.ctrl.mem_read && id_compares);

    assign fwd_id_rs = pick_src(id_rs, ma_stage, wb_stage);
    assign fwd_id_rt = pick_src(id_rt, ma_stage, wb_stage);
    assign fwd_ex_rs = pick_src(ex_stage.rs, ma_stage, wb_stage);
    assign fwd_ex_rt = pick_src(ex_stage.rt, ma_stage, wb_stage);

endmodule

`default_nettype wire

// File: hw/mips_cpu.sv
`default_nettype none

`include "mips_consts.svh"

module mips_cpu import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_t      i_inst_rdata,
    output word_t      i_inst_addr,
    input  word_t      m_data_rdata,
    output word_t      m_data_addr,
    output word_t      m_data_wdata,
    output logic [3:0] m_data_byteen,
    output logic       w_grf_we,
    output reg_addr_t  w_grf_addr,
    output word_t      w_grf_wdata,
    output word_t      w_inst_addr
);

    word_t     pc;
    word_t     id_instr;
    word_t     id_pc;
    ctrl_t     id_ctrl;
    word_t     id_imm;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     id_rs_val;
    word_t     id_rt_val;
    word_t     delay_pc;
    logic      branch_taken;
    logic      stall;
    fwd_sel_t  fwd_id_rs;
    fwd_sel_t  fwd_id_rt;
    fwd_sel_t  fwd_ex_rs;
    fwd_sel_t  fwd_ex_rt;
    id_ex_t    id_ex;
    ex_ma_t    ex_ma;
    ma_wb_t    ma_wb;
    reg_addr_t ex_dst;
    word_t     ex_rs_val;
    word_t     ex_rt_val;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    word_t     ma_fwd_data;
    word_t     wb_data;
    logic      wb_we;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf,
                                      input word_t ma, input word_t wb);
        word_t val;
        case (sel)
            `FWD_MA: val = ma;
            `FWD_WB: val = wb;
            default: val = rf;
        endcase
        return val;
    endfunction

    // Fetch
    pc_unit u_pc (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .branch_taken (branch_taken),
        .jump         (id_ctrl.is_jump),
        .jump_reg     (id_ctrl.is_jr),
        .delay_pc     (delay_pc),
        .imm          (id_imm),
        .index        (id_instr[25:0]),
        .jr_target    (id_rs_val),
        .pc           (pc)
    );

    assign i_inst_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_instr <= '0;   // Decodes as a nop
            id_pc    <= '0;
        end else if (!stall) begin
            id_instr <= i_inst_rdata;
            id_pc    <= pc;
        end
    end

    // Decode
    assign id_rs    = id_instr[25:21];
    assign id_rt    = id_instr[20:16];
    assign delay_pc = id_pc + 32'd4;

    decoder u_dec (
        .instr (id_instr),
        .ctrl  (id_ctrl),
        .imm   (id_imm)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst    (rst),
        .we     (wb_we),
        .waddr  (ma_wb.dst),
        .wdata  (wb_data),
        .raddr1 (id_rs),
        .raddr2 (id_rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    assign id_rs_val = fwd_mux(fwd_id_rs, rf_rdata1, ma_fwd_data, wb_data);
    assign id_rt_val = fwd_mux(fwd_id_rt, rf_rdata2, ma_fwd_data, wb_data);

    assign branch_taken = id_ctrl.is_branch
                       && ((id_rs_val == id_rt_val) != id_ctrl.branch_ne);

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            id_ex <= '0;   // Bubble
        end else begin
            id_ex.ctrl <= id_ctrl;
            id_ex.rs   <= id_rs;
            id_ex.rt   <= id_rt;
            id_ex.rd1  <= id_rs_val;
            id_ex.rd2  <= id_rt_val;
            id_ex.imm  <= id_imm;
            id_ex.pc   <= id_pc;
        end
    end

    // Execute
    assign ex_rs_val = fwd_mux(fwd_ex_rs, id_ex.rd1, ma_fwd_data, wb_data);
    assign ex_rt_val = fwd_mux(fwd_ex_rt, id_ex.rd2, ma_fwd_data, wb_data);
    assign alu_a     = (id_ex.ctrl.alu_op == `ALU_SLL) ? ex_rt_val : ex_rs_val;
    assign alu_b     = id_ex.ctrl.alu_src_imm ? id_ex.imm : ex_rt_val;
    assign ex_dst    = id_ex.ctrl.reg_write ? id_ex.ctrl.dst : 5'd0;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (id_ex.ctrl.alu_op),
        .result (alu_result)
    );

    hazard_unit u_hazard (
        .id_ctrl   (id_ctrl),
        .id_rs     (id_rs),
        .id_rt     (id_rt),
        .ex_stage  (id_ex),
        .ex_dst    (ex_dst),
        .ma_stage  (ex_ma),
        .wb_stage  (ma_wb),
        .stall     (stall),
        .fwd_id_rs (fwd_id_rs),
        .fwd_id_rt (fwd_id_rt),
        .fwd_ex_rs (fwd_ex_rs),
        .fwd_ex_rt (fwd_ex_rt)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_ma <= '0;
        end else begin
            ex_ma.ctrl       <= id_ex.ctrl;
            ex_ma.alu_result <= alu_result;
            ex_ma.store_data <= ex_rt_val;
            ex_ma.pc         <= id_ex.pc;
        end
    end

    // Memory
    assign m_data_addr   = ex_ma.alu_result;
    assign m_data_wdata  = ex_ma.store_data;
    assign m_data_byteen = ex_ma.ctrl.mem_write ? 4'b1111 : 4'b0000;   // Word stores only

    assign ma_fwd_data = (ex_ma.ctrl.wb_sel == `WB_LINK) ? ex_ma.pc + 32'd8
                                                         : ex_ma.alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            ma_wb <= '0;
        end else begin
            ma_wb.reg_write  <= ex_ma.ctrl.reg_write;
            ma_wb.wb_sel     <= ex_ma.ctrl.wb_sel;
            ma_wb.dst        <= ex_ma.ctrl.dst;
            ma_wb.alu_result <= ex_ma.alu_result;
            ma_wb.load_data  <= m_data_rdata;
            ma_wb.pc         <= ex_ma.pc;
        end
    end

    // Writeback
    always_comb begin
        case (ma_wb.wb_sel)
            `WB_MEM:  wb_data = ma_wb.load_data;
            `WB_LINK: wb_data = ma_wb.pc + 32'd8;
            default:  wb_data = ma_wb.alu_result;
        endcase
    end

    assign wb_we       = ma_wb.reg_write && (ma_wb.dst != 5'd0);
    assign w_grf_we    = wb_we;
    assign w_grf_addr  = ma_wb.dst;
    assign w_grf_wdata = wb_data;
    assign w_inst_addr = ma_wb.pc;

endmodule

`default_nettype wire

// File: verification/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// First instruction index of each test section
localparam int SEC_LOAD   = 13;
localparam int SEC_BRANCH = 23;
localparam int SEC_JUMP   = 37;

function automatic word_t r_type(input int rs, input int rt, input int rd, input int sh,
                                 input logic [5:0] fn);
    return {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

function automatic word_t i_type(input logic [5:0] op, input int rs, input int rt,
                                 input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic word_t j_type(input logic [5:0] op, input int t);
    word_t target;
    target = `PC_RESET + 32'(4 * t);   // t is an instruction index
    return {op, target[27:2]};
endfunction

function automatic void emit(input word_t w);
    imem[prog_len[5:0]] = w;
    prog_len++;
endfunction

function automatic void load_program();
    for (int i = 0; i < 64; i++) begin
        imem[i] = '0;
    end
    prog_len = 0;
    emit(i_type(`OP_LUI, 0, 1, 'h1234));
    emit(i_type(`OP_ORI, 1, 1, 'h5678));     // MA forward
    emit(i_type(`OP_ADDIU, 1, 2, -8));
    emit(r_type(2, 1, 3, 0, `FN_SUBU));      // MA and WB
    emit(r_type(3, 1, 4, 0, `FN_AND));
    emit(r_type(4, 3, 5, 0, `FN_OR));
    emit(r_type(3, 1, 6, 0, `FN_SLT));
    emit(r_type(0, 6, 7, 4, `FN_SLL));
    emit(r_type(7, 5, 8, 0, `FN_ADDU));
    emit(r_type(1, 3, 9, 0, `FN_SLT));
    emit(i_type(`OP_ADDIU, 0, 10, 100));
    emit(r_type(1, 2, 0, 0, `FN_ADDU));      // $0 stays quiet
    emit(r_type(10, 9, 11, 0, `FN_SUBU));
    // Loads and stores
    emit(i_type(`OP_ADDIU, 0, 12, 'h40));
    emit(i_type(`OP_LW, 12, 13, 0));
    emit(r_type(13, 1, 14, 0, `FN_ADDU));    // Load-use
    emit(i_type(`OP_SW, 12, 14, 4));
    emit(i_type(`OP_LW, 12, 15, 4));
    emit(r_type(15, 15, 16, 0, `FN_ADDU));
    emit(i_type(`OP_SW, 12, 16, 8));
    emit(i_type(`OP_LW, 12, 17, 12));
    emit(i_type(`OP_SW, 12, 17, 16));        // Store data straight from a load
    emit(i_type(`OP_ORI, 17, 18, 'hff));
    // Branches
    emit(i_type(`OP_ADDIU, 0, 20, 5));
    emit(i_type(`OP_BEQ, 20, 10, 2));        // Not taken
    emit(i_type(`OP_ADDIU, 0, 21, 1));
    emit(i_type(`OP_ADDIU, 0, 22, 2));
    emit(i_type(`OP_BNE, 20, 10, 2));        // Taken
    emit(i_type(`OP_ADDIU, 0, 23, 3));
    emit(i_type(`OP_ADDIU, 0, 24, 4));
    emit(i_type(`OP_LW, 12, 25, 0));
    emit(i_type(`OP_BEQ, 25, 13, 2));        // Taken on an operand from the load
    emit(r_type(25, 25, 26, 0, `FN_ADDU));
    emit(i_type(`OP_ADDIU, 0, 27, 7));
    emit(i_type(`OP_BNE, 25, 13, 2));
    emit(i_type(`OP_ORI, 0, 28, 9));
    emit(i_type(`OP_ADDIU, 0, 29, 10));
    // Jumps
    emit(j_type(`OP_JAL, 41));
    emit(i_type(`OP_ADDIU, 0, 2, 'h11));
    emit(j_type(`OP_J, 45));
    emit(i_type(`OP_ADDIU, 0, 3, 'h22));
    emit(r_type(31, 0, 30, 0, `FN_ADDU));
    emit(r_type(30, 0, 0, 0, `FN_JR));       // Back to the j after jal
    emit(i_type(`OP_ADDIU, 0, 5, 'h33));
    emit(i_type(`OP_ADDIU, 0, 6, 'h44));
    emit(j_type(`OP_J, 47));
    emit(i_type(`OP_ADDIU, 0, 7, 'h55));
    emit(r_type(0, 7, 8, 2, `FN_SLL));
    emit(i_type(`OP_ADDIU, 0, 9, 1));
endfunction

function automatic test_id_t test_of(input word_t pc);
    word_t idx;
    idx = (pc - `PC_RESET) >> 2;
    if (idx < 32'(SEC_LOAD)) return 3'd2;
    else if (idx < 32'(SEC_BRANCH)) return 3'd3;
    else if (idx < 32'(SEC_JUMP)) return 3'd4;
    else return 3'd5;
endfunction

// Sequential ISA model with delay slots
function automatic void run_model();
    word_t      regs [32];
    word_t      mem [1024];
    word_t      pc;
    word_t      npc;
    word_t      slot_pc;
    word_t      target;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      simm;
    word_t      addr;
    word_t      res;
    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t  dst;
    logic       wr;
    int         steps;
    wr_rec_t    w;
    st_rec_t    s;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
        mem[i] = dmem[i];
    end
    pc    = `PC_RESET;
    npc   = `PC_RESET + 32'd4;
    steps = 0;
    while (pc - `PC_RESET < 32'(4 * prog_len) && steps < 1000) begin
        ins     = imem[pc[7:2]];
        op      = ins[31:26];
        fn      = ins[5:0];
        a       = regs[ins[25:21]];
        b       = regs[ins[20:16]];
        simm    = {{16{ins[15]}}, ins[15:0]};
        slot_pc = pc + 32'd4;   // Delay slot address
        target  = npc + 32'd4;
        dst     = ins[20:16];
        res     = '0;
        wr      = 1'b1;
        case (op)
            `OP_SPECIAL: begin
                dst = ins[15:11];
                wr  = (fn != `FN_JR);
                case (fn)
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLL:  res = b << ins[10:6];
                    `FN_JR:   target = a;
                    default:  wr = 1'b0;
                endcase
            end
            `OP_ADDIU: res = a + simm;
            `OP_ORI:   res = a | {16'd0, ins[15:0]};
            `OP_LUI:   res = {ins[15:0], 16'd0};
            `OP_LW: begin
                addr = a + simm;
                res  = mem[addr[11:2]];
            end
            `OP_SW: begin
                wr   = 1'b0;
                addr = a + simm;
                mem[addr[11:2]] = b;
                s.addr = addr;
                s.data = b;
                st_q.push_back(s);
            end
            `OP_BEQ, `OP_BNE: begin
                wr = 1'b0;
                if ((a == b) == (op == `OP_BEQ)) target = slot_pc + (simm << 2);
            end
            `OP_J, `OP_JAL: begin
                wr     = (op == `OP_JAL);
                dst    = `REG_RA;
                res    = pc + 32'd8;
                target = {slot_pc[31:28], ins[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            regs[dst] = res;
            w.test = test_of(pc);
            w.addr = dst;
            w.data = res;
            w.pc   = pc;
            exp_q.push_back(w);
            total[w.test]++;
        end
        pc    = npc;
        npc   = target;
        steps++;
    end
    total[6] = st_q.size();
endfunction

`endif

// File: verification/tb_mips_cpu.sv
`default_nettype none

`include "mips_consts.svh"

module tb_mips_cpu import mips_pkg::*; ();

    typedef logic [2:0] test_id_t;

    typedef struct packed {
        test_id_t  test;
        reg_addr_t addr;
        word_t     data;
        word_t     pc;
    } wr_rec_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } st_rec_t;

    logic       clk = 1'b0;
    logic       rst;
    word_t      i_inst_rdata;
    word_t      i_inst_addr;
    word_t      m_data_rdata;
    word_t      m_data_addr;
    word_t      m_data_wdata;
    logic [3:0] m_data_byteen;
    logic       w_grf_we;
    reg_addr_t  w_grf_addr;
    word_t      w_grf_wdata;
    word_t      w_inst_addr;

    word_t   imem [64];
    word_t   dmem [1024];
    word_t   fetch_off;
    int      prog_len;
    int      seed = 57587;
    wr_rec_t exp_q [$];
    st_rec_t st_q [$];
    int      total [8];
    int      seen [8];
    int      test_err [8];
    int      wr_idx = 0;
    int      st_idx = 0;
    int      err_cnt = 0;
    int      cycle_cnt = 0;
    int      limit;
    logic    timed_out = 1'b0;

    `include "tb_program.svh"

    mips_cpu dut (
        .clk           (clk),
        .rst           (rst),
        .i_inst_rdata  (i_inst_rdata),
        .i_inst_addr   (i_inst_addr),
        .m_data_rdata  (m_data_rdata),
        .m_data_addr   (m_data_addr),
        .m_data_wdata  (m_data_wdata),
        .m_data_byteen (m_data_byteen),
        .w_grf_we      (w_grf_we),
        .w_grf_addr    (w_grf_addr),
        .w_grf_wdata   (w_grf_wdata),
        .w_inst_addr   (w_inst_addr)
    );

    always #4 clk = ~clk;

    assign fetch_off    = i_inst_addr - `PC_RESET;
    assign i_inst_rdata = (fetch_off < 32'd256) ? imem[fetch_off[7:2]] : 32'd0;   // Nops past image
    assign m_data_rdata = dmem[m_data_addr[11:2]];

    always @(posedge clk) begin
        if (!rst && m_data_byteen != 4'b0000) begin
            dmem[m_data_addr[11:2]] = m_data_wdata;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    function automatic string test_name(input test_id_t t);
        case (t)
            3'd1:    return "reset state";
            3'd2:    return "dependent ALU chain";
            3'd3:    return "load-use";
            3'd4:    return "conditional branches";
            3'd5:    return "jumps and link";
            default: return "store port";
        endcase
    endfunction

    task automatic report_test(input test_id_t t);
        $display("Test %0d %s: %0d checks, %0d mismatches",
                 t, test_name(t), total[t], test_err[t]);
    endtask

    // Writeback and store port sampled mid-cycle
    always @(negedge clk) begin
        wr_rec_t e;
        st_rec_t s;
        if (!rst && w_grf_we) begin
            if (wr_idx >= exp_q.size()) begin
                $display("Unexpected register write at %0t: $%0d = %h from pc %h",
                         $time, w_grf_addr, w_grf_wdata, w_inst_addr);
                err_cnt++;
            end else begin
                e = exp_q[wr_idx];
                if (w_grf_addr != e.addr || w_grf_wdata != e.data || w_inst_addr != e.pc) begin
                    $display("[FAIL] %0t: wrote $%0d = %h at pc %h, expected $%0d = %h at pc %h",
                             $time, w_grf_addr, w_grf_wdata, w_inst_addr, e.addr, e.data, e.pc);
                    err_cnt++;
                    test_err[e.test]++;
                end
                seen[e.test]++;
                wr_idx++;
                if (seen[e.test] == total[e.test]) begin
                    report_test(e.test);
                end
            end
        end
        if (!rst && m_data_byteen != 4'b0000) begin
            if (st_idx >= st_q.size()) begin
                $display("Unexpected store at %0t to address %h", $time, m_data_addr);
                err_cnt++;
            end else begin
                s = st_q[st_idx];
                if (m_data_byteen != 4'b1111 || m_data_addr != s.addr || m_data_wdata != s.data) begin
                    $display("[FAIL] %0t: store %h to %h byteen %b, expected %h to %h",
                             $time, m_data_wdata, m_data_addr, m_data_byteen, s.data, s.addr);
                    err_cnt++;
                    test_err[6]++;
                end
                seen[6]++;
                st_idx++;
                if (seen[6] == total[6]) begin
                    report_test(3'd6);
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = $random(seed);
        end
        load_program();
        run_model();
        total[1] = 4;
        limit    = 3 * prog_len + 20;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // Nothing reaches writeback in the first four cycles
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            if (c == 0 && i_inst_addr != `PC_RESET) begin
                $display("[FAIL] %0t: i_inst_addr %h after reset, expected %h",
                         $time, i_inst_addr, `PC_RESET);
                err_cnt++;
                test_err[1]++;
            end
            if (w_grf_we !== 1'b0 || m_data_byteen !== 4'b0000) begin
                $display("[FAIL] %0t: w_grf_we %b m_data_byteen %b after reset, expected low",
                         $time, w_grf_we, m_data_byteen);
                err_cnt++;
                test_err[1]++;
            end
        end
        report_test(3'd1);

        while ((wr_idx < exp_q.size() || st_idx < st_q.size()) && cycle_cnt < limit) begin
            @(posedge clk);
        end
        if (wr_idx < exp_q.size() || st_idx < st_q.size()) begin
            timed_out = 1'b1;
            $display("Timeout: run stopped after %0d cycles, %0d of %0d writes and %0d of %0d stores",
                     cycle_cnt, wr_idx, exp_q.size(), st_idx, st_q.size());
        end else begin
            repeat (4) @(posedge clk);   // Catch stray writes
        end

        $display("Summary: %0d register writes, %0d stores checked, %0d errors",
                 wr_idx, st_idx, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_cpu.f
+incdir+common
+incdir+verification
common/mips_pkg.sv
hw/pc_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/hazard_unit.sv
hw/mips_cpu.sv
verification/tb_mips_cpu.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log

verilator --binary -j 0 --top-module tb_mips_cpu -f mips_cpu.f \
    -Mdir obj_dir -o sim_mips_cpu \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_mips_cpu > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -qx "No errors" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
